// File: logic/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Width of every register and of the data path.
`define CORE_DATA_W 16

// Register count. The register index width follows from it.
`define CORE_NUM_REGS 8

// Rising edges from issue until the result sits on the write-back ports.
// Counts the issue edge, then the decode and execute edges.
`define CORE_WB_LATENCY 3

`endif

// File: logic/core_pkg.sv
`include "core_config.svh"

package core_pkg;

    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;

    // Codes not listed here are undefined and never write back.
    typedef enum logic [4:0] {
        op_add  = 5'd0,
        op_sub  = 5'd1,
        op_and  = 5'd2,
        op_mov  = 5'd3,  // Single operand.
        op_not  = 5'd4,  // Single operand.
        op_or   = 5'd6,
        op_xor  = 5'd7,
        op_shl  = 5'd8,  // Single operand, shift by one.
        op_shr  = 5'd9,  // Single operand, shift by one.
        op_li   = 5'd16,
        op_addi = 5'd17
    } opcode_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [1:0] unused;
    } reg_fmt_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        logic [7:0] imm;   // Zero-extended when used.
    } imm_fmt_t;

    // The same word seen as either format. Opcode and rd line up in both.
    typedef union packed {
        reg_fmt_t reg_fmt;
        imm_fmt_t imm_fmt;
    } instr_t;

    typedef struct packed {
        logic                    valid;
        opcode_t                 opcode;
        reg_idx_t                rd;
        reg_idx_t                rs1;
        reg_idx_t                rs2;
        logic                    use_imm;
        logic [`CORE_DATA_W-1:0] imm;
    } dec_t;

    typedef struct packed {
        logic                    valid;
        opcode_t                 opcode;
        reg_idx_t                rd;
        logic [`CORE_DATA_W-1:0] a;
        logic [`CORE_DATA_W-1:0] b;
    } exe_t;

    typedef struct packed {
        logic                    valid;
        reg_idx_t                rd;
        logic [`CORE_DATA_W-1:0] data;
    } wb_t;

endpackage

// File: logic/instr_decoder.sv
`timescale 1ns/10ps
`include "core_config.svh"

module instr_decoder (
    input  core_pkg::instr_t instr,
    input  logic             instr_valid,
    output core_pkg::dec_t   dec
);

    localparam int DW = `CORE_DATA_W;

    always_comb begin
        dec         = '0;
        dec.opcode  = instr.reg_fmt.opcode;
        dec.rd      = instr.reg_fmt.rd;  // Same bits in both views.

        case (instr.reg_fmt.opcode)
            core_pkg::op_add,
            core_pkg::op_sub,
            core_pkg::op_and,
            core_pkg::op_or,
            core_pkg::op_xor: begin
                dec.valid = instr_valid;
                dec.rs1   = instr.reg_fmt.rs1;
                dec.rs2   = instr.reg_fmt.rs2;
            end

            core_pkg::op_mov,
            core_pkg::op_not,
            core_pkg::op_shl,
            core_pkg::op_shr: begin
                // Only one source, taken from the first register field.
                dec.valid = instr_valid;
                dec.rs1   = instr.reg_fmt.rs1;
                dec.rs2   = instr.reg_fmt.rs1;
            end

            core_pkg::op_li: begin
                dec.valid   = instr_valid;
                dec.rs1     = instr.imm_fmt.rd;
                dec.rs2     = instr.imm_fmt.rd;
                dec.use_imm = 1'b1;
                dec.imm     = DW'(instr.imm_fmt.imm);
            end

            core_pkg::op_addi: begin
                // The immediate format has no separate source field.
                // Add-immediate reads rd and accumulates into it.
                dec.valid   = instr_valid;
                dec.rs1     = instr.imm_fmt.rd;
                dec.rs2     = instr.imm_fmt.rd;
                dec.use_imm = 1'b1;
                dec.imm     = DW'(instr.imm_fmt.imm);
            end

            default: begin
                dec.valid = 1'b0;  // Undefined opcode is dropped here.
            end
        endcase
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/10ps
`include "core_config.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  core_pkg::reg_idx_t      rd_addr_a,
    input  core_pkg::reg_idx_t      rd_addr_b,
    output logic [`CORE_DATA_W-1:0] rd_data_a,
    output logic [`CORE_DATA_W-1:0] rd_data_b,
    input  core_pkg::wb_t           wr
);

    localparam int DW = `CORE_DATA_W;

    logic [DW-1:0] regs [`CORE_NUM_REGS];

    // After reset every register holds its own index.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= DW'(i);
            end
        end else if (wr.valid) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Reads see the array as it stands. A write in flight is forwarded
    // elsewhere, so no bypass is needed here.
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

// File: logic/operand_forward.sv
`timescale 1ns/10ps
`include "core_config.svh"

module operand_forward (
    input  core_pkg::dec_t          dec,
    input  logic [`CORE_DATA_W-1:0] file_a,
    input  logic [`CORE_DATA_W-1:0] file_b,
    input  core_pkg::wb_t           exe_fwd,  // One instruction ahead.
    input  core_pkg::wb_t           wb_fwd,   // Two instructions ahead.
    output core_pkg::exe_t          operands
);

    // The nearest older producer of the source wins.
    function automatic logic [`CORE_DATA_W-1:0] select_src(
        input core_pkg::reg_idx_t      src,
        input logic [`CORE_DATA_W-1:0] file_val
    );
        if (exe_fwd.valid && exe_fwd.rd == src) begin
            return exe_fwd.data;
        end
        if (wb_fwd.valid && wb_fwd.rd == src) begin
            return wb_fwd.data;
        end
        return file_val;
    endfunction

    always_comb begin
        operands.valid  = dec.valid;
        operands.opcode = dec.opcode;
        operands.rd     = dec.rd;
        operands.a      = select_src(dec.rs1, file_a);

        if (dec.use_imm) begin
            operands.b = dec.imm;
        end else begin
            operands.b = select_src(dec.rs2, file_b);
        end
    end

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/10ps
`include "core_config.svh"

module exec_unit (
    input  logic           clk,
    input  logic           reset,
    input  core_pkg::exe_t exe,
    output core_pkg::wb_t  result,
    output core_pkg::wb_t  wb
);

    logic [`CORE_DATA_W-1:0] alu_out;

    // All arithmetic wraps at the data width.
    always_comb begin
        case (exe.opcode)
            core_pkg::op_add: begin
                alu_out = exe.a + exe.b;
            end
            core_pkg::op_sub: begin
                alu_out = exe.a - exe.b;
            end
            core_pkg::op_and: begin
                alu_out = exe.a & exe.b;
            end
            core_pkg::op_or: begin
                alu_out = exe.a | exe.b;
            end
            core_pkg::op_xor: begin
                alu_out = exe.a ^ exe.b;
            end
            core_pkg::op_mov: begin
                alu_out = exe.a;
            end
            core_pkg::op_not: begin
                alu_out = ~exe.a;
            end
            core_pkg::op_shl: begin
                alu_out = exe.a << 1;
            end
            core_pkg::op_shr: begin
                alu_out = exe.a >> 1;  // Logical shift, zero fill.
            end
            core_pkg::op_li: begin
                alu_out = exe.b;
            end
            core_pkg::op_addi: begin
                alu_out = exe.a + exe.b;
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

    // Also feeds the forwarding path for the next instruction.
    assign result.valid = exe.valid;
    assign result.rd    = exe.rd;
    assign result.data  = alu_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= result.valid;
        end
        wb.rd   <= result.rd;
        wb.data <= result.data;
    end

endmodule

// File: logic/core_pipe.sv
`timescale 1ns/10ps
`include "core_config.svh"

module core_pipe (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instr_valid,
    input  core_pkg::instr_t        instr,
    output logic                    wb_valid,
    output core_pkg::reg_idx_t      wb_rd,
    output logic [`CORE_DATA_W-1:0] wb_data
);

    core_pkg::dec_t          dec_next;
    core_pkg::dec_t          dec_q;
    core_pkg::exe_t          exe_next;
    core_pkg::exe_t          exe_q;
    core_pkg::wb_t           exe_result;
    core_pkg::wb_t           wb;
    logic [`CORE_DATA_W-1:0] file_a;
    logic [`CORE_DATA_W-1:0] file_b;

    instr_decoder u_decoder (
        .instr       (instr),
        .instr_valid (instr_valid),
        .dec         (dec_next)
    );

    // Decode stage register, captured on the issue edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_q.valid <= 1'b0;
        end else begin
            dec_q.valid <= dec_next.valid;
        end
        dec_q.opcode  <= dec_next.opcode;
        dec_q.rd      <= dec_next.rd;
        dec_q.rs1     <= dec_next.rs1;
        dec_q.rs2     <= dec_next.rs2;
        dec_q.use_imm <= dec_next.use_imm;
        dec_q.imm     <= dec_next.imm;
    end

    reg_file u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (dec_q.rs1),
        .rd_addr_b (dec_q.rs2),
        .rd_data_a (file_a),
        .rd_data_b (file_b),
        .wr        (wb)
    );

    operand_forward u_forward (
        .dec      (dec_q),
        .file_a   (file_a),
        .file_b   (file_b),
        .exe_fwd  (exe_result),
        .wb_fwd   (wb),
        .operands (exe_next)
    );

    // Operand stage register feeding execute.
    always_ff @(posedge clk) begin
        if (reset) begin
            exe_q.valid <= 1'b0;
        end else begin
            exe_q.valid <= exe_next.valid;
        end
        exe_q.opcode <= exe_next.opcode;
        exe_q.rd     <= exe_next.rd;
        exe_q.a      <= exe_next.a;
        exe_q.b      <= exe_next.b;
    end

    exec_unit u_exec (
        .clk    (clk),
        .reset  (reset),
        .exe    (exe_q),
        .result (exe_result),
        .wb     (wb)
    );

    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

// File: test/core_pipe_chk.sv
`timescale 1ns/10ps
`include "core_config.svh"

module core_pipe_chk (
    input logic             clk,
    input logic             reset,
    input logic             instr_valid,
    input core_pkg::instr_t instr,
    input core_pkg::dec_t   dec_q,
    input core_pkg::exe_t   exe_q,
    input logic             wb_valid
);

    localparam int LAT = `CORE_WB_LATENCY;

    logic defined_issue;

    assign defined_issue = instr_valid && (instr.reg_fmt.opcode inside {
        core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and, core_pkg::op_or,
        core_pkg::op_xor, core_pkg::op_mov, core_pkg::op_not, core_pkg::op_shl,
        core_pkg::op_shr, core_pkg::op_li, core_pkg::op_addi
    });

    // Every stage valid is clear in the cycle after a reset edge.
    reset_clears_stages: assert property (
        @(posedge clk) reset |=> !wb_valid && !dec_q.valid && !exe_q.valid
    ) else $error("stage valid set in the cycle after reset");

    issue_enters_decode: assert property (
        @(posedge clk) disable iff (reset) defined_issue |=> dec_q.valid
    ) else $error("defined issue did not reach the decode register");

    // Fixed latency, in both directions, so write-back is exactly LAT edges after issue.
    issue_reaches_wb: assert property (
        @(posedge clk) disable iff (reset) defined_issue |-> ##LAT wb_valid
    ) else $error("no write-back at the fixed latency after a defined issue");

    no_issue_no_wb: assert property (
        @(posedge clk) disable iff (reset) !defined_issue |-> ##LAT !wb_valid
    ) else $error("write-back without a matching defined issue");

endmodule

// File: test/core_pipe_tb.sv
`timescale 1ns/10ps
`include "core_config.svh"

module core_pipe_tb;

    localparam int DW          = `CORE_DATA_W;
    localparam int NR          = `CORE_NUM_REGS;
    localparam int LAT         = `CORE_WB_LATENCY;
    localparam int DRAIN_LIMIT = 20;

    // One predicted write-back, tagged with its issue cycle.
    typedef struct packed {
        int unsigned        cycle;
        core_pkg::reg_idx_t rd;
        logic [DW-1:0]      data;
    } expect_t;

    logic               clk = 1'b0;
    logic               reset;
    logic               instr_valid;
    core_pkg::instr_t   instr;
    logic               wb_valid;
    core_pkg::reg_idx_t wb_rd;
    logic [DW-1:0]      wb_data;

    logic [DW-1:0]      model [NR];
    expect_t            pending [$];
    int unsigned        cycle;
    core_pkg::opcode_t  all_ops [11];  // Register ops first, then the two immediate ops.

    core_pipe dut0 (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    bind core_pipe core_pipe_chk chk0 (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_q       (dec_q),
        .exe_q       (exe_q),
        .wb_valid    (wb_valid)
    );

    initial begin
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    // Result of one instruction from the opcode rules.
    function automatic logic [DW-1:0] predict(input core_pkg::opcode_t op,
                                              input logic [DW-1:0] a,
                                              input logic [DW-1:0] b);
        logic [DW-1:0] res;
        case (op)
            core_pkg::op_add:  res = a + b;
            core_pkg::op_sub:  res = a - b;
            core_pkg::op_and:  res = a & b;
            core_pkg::op_or:   res = a | b;
            core_pkg::op_xor:  res = a ^ b;
            core_pkg::op_mov:  res = a;
            core_pkg::op_not:  res = ~a;
            core_pkg::op_shl:  res = {a[DW-2:0], 1'b0};
            core_pkg::op_shr:  res = {1'b0, a[DW-1:1]};
            core_pkg::op_li:   res = b;
            core_pkg::op_addi: res = a + b;
            default:           res = '0;
        endcase
        return res;
    endfunction

    function automatic logic is_defined(input logic [4:0] code);
        return code inside {
            core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and, core_pkg::op_or,
            core_pkg::op_xor, core_pkg::op_mov, core_pkg::op_not, core_pkg::op_shl,
            core_pkg::op_shr, core_pkg::op_li, core_pkg::op_addi
        };
    endfunction

    task automatic check_writeback();
        expect_t head;
        if (wb_valid) begin
            assert (pending.size() != 0) else begin
                $display("Write-back at cycle %0d with no result outstanding.", cycle);
                stop_run();
            end
            head = pending.pop_front();
            assert (cycle == head.cycle + LAT) else begin
                $display("** Error: wb_valid at cycle %h, expected at cycle %h",
                         cycle, head.cycle + LAT);
                stop_run();
            end
            assert (wb_rd == head.rd) else begin
                $display("** Error: wb_rd = %h, expected %h", wb_rd, head.rd);
                stop_run();
            end
            assert (wb_data == head.data) else begin
                $display("** Error: wb_data = %h, expected %h", wb_data, head.data);
                stop_run();
            end
        end else if (pending.size() != 0) begin
            assert (cycle != pending[0].cycle + LAT) else begin
                $display("No write-back for the instruction issued at cycle %0d.",
                         pending[0].cycle);
                stop_run();
            end
        end
    endtask

    // Outputs are settled at the falling edge, so they are checked there.
    task automatic tick();
        @(negedge clk);
        cycle++;
        check_writeback();
    endtask

    task automatic push_expect(input core_pkg::reg_idx_t rd, input logic [DW-1:0] data);
        expect_t entry;
        entry.cycle = cycle;
        entry.rd    = rd;
        entry.data  = data;
        model[rd]   = data;
        pending.push_back(entry);
    endtask

    task automatic issue_reg(input core_pkg::opcode_t op, input core_pkg::reg_idx_t rd,
                             input core_pkg::reg_idx_t rs1, input core_pkg::reg_idx_t rs2);
        tick();
        instr                = '0;
        instr.reg_fmt.opcode = op;
        instr.reg_fmt.rd     = rd;
        instr.reg_fmt.rs1    = rs1;
        instr.reg_fmt.rs2    = rs2;
        instr_valid          = 1'b1;
        push_expect(rd, predict(op, model[rs1], model[rs2]));
    endtask

    // The immediate forms read and write the same register.
    task automatic issue_imm(input core_pkg::opcode_t op, input core_pkg::reg_idx_t rd,
                             input logic [7:0] imm);
        tick();
        instr                = '0;
        instr.imm_fmt.opcode = op;
        instr.imm_fmt.rd     = rd;
        instr.imm_fmt.imm    = imm;
        instr_valid          = 1'b1;
        push_expect(rd, predict(op, model[rd], DW'(imm)));
    endtask

    task automatic issue_undefined();
        logic [4:0] code;
        code = 5'($urandom());
        while (is_defined(code)) begin
            code = 5'($urandom());
        end
        tick();
        instr       = {code, 11'($urandom())};
        instr_valid = 1'b1;  // Nothing is expected back.
    endtask

    task automatic idle();
        tick();
        instr       = 16'($urandom());
        instr_valid = 1'b0;
    endtask

    task automatic issue_random(input int last_op);
        core_pkg::opcode_t op;
        int                idx;
        idx = int'($urandom_range(last_op, 0));
        op  = all_ops[idx];
        if (op == core_pkg::op_li || op == core_pkg::op_addi) begin
            issue_imm(op, core_pkg::reg_idx_t'($urandom()), 8'($urandom()));
        end else begin
            issue_reg(op, core_pkg::reg_idx_t'($urandom()),
                      core_pkg::reg_idx_t'($urandom()), core_pkg::reg_idx_t'($urandom()));
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'h4cbe));
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        cycle       = 0;
        all_ops = '{core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and, core_pkg::op_or,
                    core_pkg::op_xor, core_pkg::op_mov, core_pkg::op_not, core_pkg::op_shl,
                    core_pkg::op_shr, core_pkg::op_li, core_pkg::op_addi};
        for (int i = 0; i < NR; i++) begin
            model[i] = DW'(i);
        end
        tick();
        tick();
        reset = 1'b0;

        for (int i = 0; i < 3; i++) begin
            tick();
            assert (!wb_valid) else begin
                $display("** Error: wb_valid = %h after reset, expected 0", wb_valid);
                stop_run();
            end
        end

        // Each register reads back its own index.
        for (int r = 0; r < NR; r++) begin
            issue_reg(core_pkg::op_mov, core_pkg::reg_idx_t'(r),
                      core_pkg::reg_idx_t'(r), core_pkg::reg_idx_t'(r));
            repeat (4) idle();
        end

        issue_imm(core_pkg::op_li, 3'd1, 8'hff);
        repeat (8) issue_reg(core_pkg::op_shl, 3'd1, 3'd1, 3'd1);  // Leaves 0xff00.
        issue_reg(core_pkg::op_add, 3'd2, 3'd1, 3'd1);               // Wraps.
        issue_imm(core_pkg::op_li, 3'd3, 8'h80);
        issue_imm(core_pkg::op_addi, 3'd3, 8'hff);
        issue_reg(core_pkg::op_sub, 3'd4, 3'd0, 3'd1);
        issue_reg(core_pkg::op_shr, 3'd5, 3'd1, 3'd1);
        issue_reg(core_pkg::op_not, 3'd6, 3'd3, 3'd3);

        // Sources one, two and three instructions back, with no gaps.
        issue_reg(core_pkg::op_add, 3'd1, 3'd2, 3'd3);
        issue_reg(core_pkg::op_sub, 3'd4, 3'd1, 3'd2);
        issue_reg(core_pkg::op_xor, 3'd5, 3'd1, 3'd4);
        issue_reg(core_pkg::op_or, 3'd6, 3'd1, 3'd5);
        issue_reg(core_pkg::op_and, 3'd7, 3'd4, 3'd6);
        repeat (6) issue_imm(core_pkg::op_addi, 3'd7, 8'h41);
        issue_reg(core_pkg::op_add, 3'd7, 3'd7, 3'd7);

        repeat (120) issue_random(8);

        for (int i = 0; i < 400; i++) begin
            n = int'($urandom_range(7, 0));
            if (n == 0) begin
                idle();
            end else if (n == 1) begin
                issue_undefined();
            end else begin
                issue_random(10);
            end
        end

        idle();
        for (n = 0; pending.size() != 0; n++) begin
            if (n == DRAIN_LIMIT) begin
                $display("Timed out with %0d write-backs outstanding.", pending.size());
                stop_run();
            end else begin
                idle();
            end
        end
        repeat (4) idle();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: sources.f
+incdir+logic
logic/core_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/exec_unit.sv
logic/core_pipe.sv
test/core_pipe_chk.sv
test/core_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module core_pipe_tb -f sources.f -o core_pipe_sim

status=0
./obj_dir/core_pipe_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without passing"
    exit 1
fi
exit 0
